/* build.f */
verilog/bus_pkg.sv
verilog/mem_pkg.sv
verilog/mem_access_unit.sv
verilog/sram_arbiter.sv
verilog/data_sram.sv
verilog/dmem_subsystem.sv
sim/dmem_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the data memory testbench with verilator
# exit status is zero only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module dmem_tb -Mdir obj_dir -f build.f \
	&& ./obj_dir/Vdmem_tb | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/dmem_tb.sv */
`timescale 1ns/100ps

module dmem_tb;
	import bus_pkg::*;
	import mem_pkg::*;

	localparam int ADDR_W = 12;
	localparam int MEM_BYTES = 2 ** ADDR_W;
	localparam logic [31:0] SEED = 32'hf8f0_27b5;

	// test sizes
	localparam int RT_WORDS = 200;
	localparam int NARROW_ROUNDS = 100;
	localparam int NL_PATTERNS = 2;
	localparam int CONTEND_PAIRS = 100;
	localparam int COHERE_ROUNDS = 50;

	// one cycle per uncontended access
	// under contention both ports share one sram slot per cycle
	// plus reset, idle check and a few drain cycles per test
	localparam int TEST_CYCLES = 16 + 2 * RT_WORDS + 4 * NARROW_ROUNDS + 17 * NL_PATTERNS
		+ 4 * CONTEND_PAIRS + 4 * COHERE_ROUNDS + 8 * 6;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic clk = 1'b0;
	logic rst_n;

	logic              a_req;
	logic              a_we;
	access_t           a_sel;
	logic [ADDR_W-1:0] a_addr;
	word_t             a_wdata;
	logic              a_gnt;
	word_t             a_rdata;
	logic              a_rvalid;

	logic              b_req;
	logic              b_we;
	access_t           b_sel;
	logic [ADDR_W-1:0] b_addr;
	word_t             b_wdata;
	logic              b_gnt;
	word_t             b_rdata;
	logic              b_rvalid;

	// byte wide reference memory
	logic [7:0] ref_mem [MEM_BYTES];
	// expected load results per port, in issue order
	word_t exp_a [$];
	word_t exp_b [$];

	int    fail_count = 0;
	int    fail_mark = 0;
	int    pass_tests = 0;
	int    fail_tests = 0;
	int    cycle_count = 0;
	string cur_test = "none";

	dmem_subsystem #(
		.ADDR_W(ADDR_W)
	) dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.a_req   (a_req),
		.a_we    (a_we),
		.a_sel   (a_sel),
		.a_addr  (a_addr),
		.a_wdata (a_wdata),
		.a_gnt   (a_gnt),
		.a_rdata (a_rdata),
		.a_rvalid(a_rvalid),
		.b_req   (b_req),
		.b_we    (b_we),
		.b_sel   (b_sel),
		.b_addr  (b_addr),
		.b_wdata (b_wdata),
		.b_gnt   (b_gnt),
		.b_rdata (b_rdata),
		.b_rvalid(b_rvalid)
	);

	// 8 ns period
	always #4 clk = ~clk;

	function automatic void note_failure(string what);
		fail_count++;
		$display("check failed at %0t: %s", $time, what);
	endfunction

	// at most one grant per cycle
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0({a_gnt, b_gnt}))
		else note_failure("more than one port granted in the same cycle");
	// no grant without a request
	assert property (@(posedge clk) disable iff (!rst_n) a_gnt |-> a_req)
		else note_failure("port a granted without a request");
	assert property (@(posedge clk) disable iff (!rst_n) b_gnt |-> b_req)
		else note_failure("port b granted without a request");
	// rvalid exactly one cycle after a load grant
	assert property (@(posedge clk) disable iff (!rst_n) a_rvalid == $past(a_gnt && !a_we))
		else note_failure("port a rvalid does not follow its load grant by one cycle");
	assert property (@(posedge clk) disable iff (!rst_n) b_rvalid == $past(b_gnt && !b_we))
		else note_failure("port b rvalid does not follow its load grant by one cycle");
	// a losing port wins the next cycle
	assert property (@(posedge clk) disable iff (!rst_n) (a_req && !a_gnt) |=> a_gnt)
		else note_failure("port a waited more than one cycle for a grant");
	assert property (@(posedge clk) disable iff (!rst_n) (b_req && !b_gnt) |=> b_gnt)
		else note_failure("port b waited more than one cycle for a grant");

	// store into the model, narrow widths ignore the low bits beyond their size
	function automatic void apply_store(access_t sel, logic [ADDR_W-1:0] addr, word_t data);
		logic [ADDR_W-1:0] base;
		case (sel)
			ACC_BYTE: begin
				ref_mem[addr] = data[7:0];
			end
			ACC_HALF: begin
				base = {addr[ADDR_W-1:1], 1'b0};
				ref_mem[base] = data[7:0];
				ref_mem[base + ADDR_W'(1)] = data[15:8];
			end
			default: begin
				base = {addr[ADDR_W-1:2], 2'b00};
				for (int i = 0; i < 4; i++) begin
					ref_mem[base + ADDR_W'(i)] = data[i*8 +: 8];
				end
			end
		endcase
	endfunction

	// expected load result from the model
	function automatic word_t expected_load(access_t sel, logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] wbase;
		logic [ADDR_W-1:0] hbase;
		logic [7:0]        lo;
		logic [15:0]       half;
		word_t             whole;
		word_t             result;
		wbase = {addr[ADDR_W-1:2], 2'b00};
		hbase = {addr[ADDR_W-1:1], 1'b0};
		lo = ref_mem[addr];
		half = {ref_mem[hbase + ADDR_W'(1)], ref_mem[hbase]};
		whole = {ref_mem[wbase + ADDR_W'(3)], ref_mem[wbase + ADDR_W'(2)],
			ref_mem[wbase + ADDR_W'(1)], ref_mem[wbase]};
		case (sel)
			ACC_LBU: result = {24'h0, lo};
			ACC_LB:  result = {{24{lo[7]}}, lo};
			ACC_LHU: result = {16'h0, half};
			ACC_LH:  result = {{16{half[15]}}, half};
			default: result = whole;
		endcase
		return result;
	endfunction

	// granted access, stores hit the model, loads queue an expectation
	function automatic void record_access(int port, logic we, access_t sel,
			logic [ADDR_W-1:0] addr, word_t data);
		if (we) begin
			apply_store(sel, addr, data);
		end else if (port == 0) begin
			exp_a.push_back(expected_load(sel, addr));
		end else begin
			exp_b.push_back(expected_load(sel, addr));
		end
	endfunction

	function automatic void check_load(int port, word_t actual);
		word_t expected;
		if ((port == 0 && exp_a.size() == 0) || (port == 1 && exp_b.size() == 0)) begin
			note_failure($sformatf("%s: port %0d returned read data with no load pending",
				cur_test, port));
		end else begin
			expected = (port == 0) ? exp_a.pop_front() : exp_b.pop_front();
			assert (actual == expected)
			else begin
				fail_count++;
				$display("** Error: %s port %0d expected %08h actual %08h",
					cur_test, port, expected, actual);
			end
		end
	endfunction

	// monitor, values sampled at the edge belong to the cycle just ending
	always @(posedge clk) begin
		if (rst_n) begin
			if (a_gnt) begin
				record_access(0, a_we, a_sel, a_addr, a_wdata);
			end
			if (b_gnt) begin
				record_access(1, b_we, b_sel, b_addr, b_wdata);
			end
			if (a_rvalid) begin
				check_load(0, a_rdata);
			end
			if (b_rvalid) begin
				check_load(1, b_rdata);
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic granted(int port);
		return (port == 0) ? a_gnt : b_gnt;
	endfunction

	// drive one access and hold it until granted
	task automatic issue(int port, logic we, access_t sel, logic [ADDR_W-1:0] addr,
			word_t data);
		if (port == 0) begin
			a_req <= 1'b1;
			a_we <= we;
			a_sel <= sel;
			a_addr <= addr;
			a_wdata <= data;
		end else begin
			b_req <= 1'b1;
			b_we <= we;
			b_sel <= sel;
			b_addr <= addr;
			b_wdata <= data;
		end
		do begin
			@(posedge clk);
		end while (!granted(port));
	endtask

	task automatic release_port(int port);
		if (port == 0) begin
			a_req <= 1'b0;
			a_we <= 1'b0;
		end else begin
			b_req <= 1'b0;
			b_we <= 1'b0;
		end
	endtask

	function automatic logic [ADDR_W-1:0] random_word_addr();
		logic [ADDR_W-1:0] addr;
		addr = ADDR_W'($urandom());
		addr[1:0] = 2'b00;
		return addr;
	endfunction

	task automatic begin_test(string name);
		cur_test = name;
		fail_mark = fail_count;
	endtask

	// let outstanding loads come back, then report
	task automatic end_test();
		release_port(0);
		release_port(1);
		@(posedge clk);
		while (exp_a.size() != 0 || exp_b.size() != 0) begin
			@(posedge clk);
		end
		if (fail_count == fail_mark) begin
			pass_tests++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_tests++;
			$display("test %s: %0d check(s) failed", cur_test, fail_count - fail_mark);
		end
	endtask

	task automatic check_reset_state();
		begin_test("reset_state");
		repeat (6) begin
			@(posedge clk);
			assert (!a_gnt && !b_gnt && !a_rvalid && !b_rvalid && !dut.sram_en)
			else note_failure("reset_state: gnt, rvalid or sram enable active while idle");
		end
		end_test();
	endtask

	task automatic word_round_trip();
		logic [ADDR_W-1:0] addrs [RT_WORDS];
		begin_test("word_round_trip");
		for (int i = 0; i < RT_WORDS; i++) begin
			addrs[i] = random_word_addr();
			issue(0, 1'b1, ACC_WORD, addrs[i], $urandom());
		end
		// back to back loads
		for (int i = 0; i < RT_WORDS; i++) begin
			issue(0, 1'b0, ACC_WORD, addrs[i], '0);
		end
		end_test();
	endtask

	task automatic narrow_stores();
		logic [ADDR_W-1:0] base;
		begin_test("narrow_stores");
		for (int r = 0; r < NARROW_ROUNDS; r++) begin
			base = random_word_addr();
			issue(0, 1'b1, ACC_WORD, base, $urandom());
			issue(0, 1'b1, ACC_BYTE, base | ADDR_W'($urandom() % 4), $urandom());
			// odd offsets too, bit 0 is ignored
			issue(0, 1'b1, ACC_HALF, base | ADDR_W'($urandom() % 4), $urandom());
			issue(0, 1'b0, ACC_WORD, base, '0);
		end
		end_test();
	endtask

	task automatic narrow_loads();
		// both patterns together give set and clear msbs on every byte and half
		word_t             patterns [NL_PATTERNS] = '{32'h12f0_7f81, 32'h807e_ff01};
		access_t           fmts [4] = '{ACC_LBU, ACC_LB, ACC_LHU, ACC_LH};
		logic [ADDR_W-1:0] base;
		begin_test("narrow_loads");
		for (int p = 0; p < NL_PATTERNS; p++) begin
			base = random_word_addr();
			issue(0, 1'b1, ACC_WORD, base, patterns[p]);
			for (int f = 0; f < 4; f++) begin
				for (int off = 0; off < 4; off++) begin
					issue(0, 1'b0, fmts[f], base | ADDR_W'(off), '0);
				end
			end
		end
		end_test();
	endtask

	// store then load each word of a private region, no gaps
	task automatic contend_port(int port, logic [ADDR_W-1:0] region);
		logic [ADDR_W-1:0] addr;
		for (int i = 0; i < CONTEND_PAIRS; i++) begin
			addr = region + ADDR_W'(i * 4);
			issue(port, 1'b1, ACC_WORD, addr, $urandom());
			issue(port, 1'b0, ACC_WORD, addr, '0);
		end
		release_port(port);
	endtask

	task automatic contention();
		begin_test("contention");
		fork
			contend_port(0, ADDR_W'('h400));
			contend_port(1, ADDR_W'('h800));
		join
		end_test();
	endtask

	task automatic cross_port_coherence();
		logic [ADDR_W-1:0] base;
		logic [ADDR_W-1:0] off;
		begin_test("cross_port_coherence");
		for (int r = 0; r < COHERE_ROUNDS; r++) begin
			base = random_word_addr();
			off = ADDR_W'($urandom() % 4);
			issue(1, 1'b1, ACC_WORD, base, $urandom());
			release_port(1);
			issue(0, 1'b0, ACC_WORD, base, '0);
			release_port(0);
			issue(1, 1'b1, ACC_BYTE, base | off, $urandom());
			release_port(1);
			issue(0, 1'b0, ACC_LBU, base | off, '0);
			release_port(0);
		end
		end_test();
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		a_req = 1'b0;
		a_we = 1'b0;
		a_sel = ACC_WORD;
		a_addr = '0;
		a_wdata = '0;
		b_req = 1'b0;
		b_we = 1'b0;
		b_sel = ACC_WORD;
		b_addr = '0;
		b_wdata = '0;
		for (int i = 0; i < MEM_BYTES; i++) begin
			ref_mem[i] = 8'h00;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		check_reset_state();
		word_round_trip();
		narrow_stores();
		narrow_loads();
		contention();
		cross_port_coherence();

		$display("tests passed %0d failed %0d, failed checks %0d",
			pass_tests, fail_tests, fail_count);
		if (fail_count == 0 && fail_tests == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* verilog/bus_pkg.sv */
package bus_pkg;

	// sram side bus geometry
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;
	localparam int STRB_W = WORD_W / BYTE_W;

	// arbitrated requesters, port a is index 0
	localparam int NUM_PORTS = 2;

	// one data word on port and sram side
	typedef logic [WORD_W-1:0] word_t;

	// byte lane write strobe
	// bit i covers bits 8i+7 down to 8i
	typedef logic [STRB_W-1:0] strb_t;

	// port index for the arbiter pointer and mux
	typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

endpackage

/* verilog/data_sram.sv */
`timescale 1ns/100ps

module data_sram #(
	parameter int ADDR_W = 12
) (
	input  logic                 clk,
	input  logic                 en,
	input  bus_pkg::strb_t       wen,
	input  logic [ADDR_W-3:0]    addr,
	input  bus_pkg::word_t       wdata,
	output bus_pkg::word_t       rdata
);
	import bus_pkg::*;

	// one entry per 32 bit word
	localparam int DEPTH = 2 ** (ADDR_W - 2);

	word_t mem [DEPTH];

	// byte lane writes
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wen[i]) begin
					mem[addr][i*BYTE_W +: BYTE_W] <= wdata[i*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// registered read port
	// same cycle write leaves old data on rdata
	// updated on every enabled cycle, reads and writes alike
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[addr];
		end
	end

endmodule

/* verilog/dmem_subsystem.sv */
`timescale 1ns/100ps

module dmem_subsystem #(
	parameter int ADDR_W = 12
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// port a, cpu data side
	input  logic                 a_req,
	input  logic                 a_we,
	input  mem_pkg::access_t     a_sel,
	input  logic [ADDR_W-1:0]    a_addr,
	input  bus_pkg::word_t       a_wdata,
	output logic                 a_gnt,
	output bus_pkg::word_t       a_rdata,
	output logic                 a_rvalid,

	// port b, debug or dma side
	input  logic                 b_req,
	input  logic                 b_we,
	input  mem_pkg::access_t     b_sel,
	input  logic [ADDR_W-1:0]    b_addr,
	input  bus_pkg::word_t       b_wdata,
	output logic                 b_gnt,
	output bus_pkg::word_t       b_rdata,
	output logic                 b_rvalid
);
	import bus_pkg::*;

	// unit to arbiter, index 0 is port a
	logic [NUM_PORTS-1:0]             m_req;
	strb_t [NUM_PORTS-1:0]            m_wen;
	logic [NUM_PORTS-1:0][ADDR_W-3:0] m_addr;
	word_t [NUM_PORTS-1:0]            m_wdata;

	// arbiter to sram
	logic              sram_en;
	strb_t             sram_wen;
	logic [ADDR_W-3:0] sram_addr;
	word_t             sram_wdata;
	// sram read data, shared by both units
	word_t             sram_rdata;

	mem_access_unit #(
		.ADDR_W(ADDR_W)
	) u_unit_a (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (a_req),
		.we        (a_we),
		.sel       (a_sel),
		.addr      (a_addr),
		.wdata     (a_wdata),
		.rdata     (a_rdata),
		.rvalid    (a_rvalid),
		.mreq      (m_req[0]),
		.mwen      (m_wen[0]),
		.maddr     (m_addr[0]),
		.mwdata    (m_wdata[0]),
		.mgnt      (a_gnt),
		.sram_rdata(sram_rdata)
	);

	mem_access_unit #(
		.ADDR_W(ADDR_W)
	) u_unit_b (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (b_req),
		.we        (b_we),
		.sel       (b_sel),
		.addr      (b_addr),
		.wdata     (b_wdata),
		.rdata     (b_rdata),
		.rvalid    (b_rvalid),
		.mreq      (m_req[1]),
		.mwen      (m_wen[1]),
		.maddr     (m_addr[1]),
		.mwdata    (m_wdata[1]),
		.mgnt      (b_gnt),
		.sram_rdata(sram_rdata)
	);

	// grant bits fan back out as the port gnt pulses
	sram_arbiter #(
		.ADDR_W(ADDR_W)
	) u_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (m_req),
		.wen       (m_wen),
		.addr      (m_addr),
		.wdata     (m_wdata),
		.gnt       ({b_gnt, a_gnt}),
		.sram_en   (sram_en),
		.sram_wen  (sram_wen),
		.sram_addr (sram_addr),
		.sram_wdata(sram_wdata)
	);

	data_sram #(
		.ADDR_W(ADDR_W)
	) u_sram (
		.clk  (clk),
		.en   (sram_en),
		.wen  (sram_wen),
		.addr (sram_addr),
		.wdata(sram_wdata),
		.rdata(sram_rdata)
	);

endmodule

/* verilog/mem_access_unit.sv */
`timescale 1ns/100ps

module mem_access_unit #(
	parameter int ADDR_W = 12
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  logic                 we,
	input  mem_pkg::access_t     sel,
	input  logic [ADDR_W-1:0]    addr,
	input  bus_pkg::word_t       wdata,
	output bus_pkg::word_t       rdata,
	output logic                 rvalid,
	output logic                 mreq,
	output bus_pkg::strb_t       mwen,
	output logic [ADDR_W-3:0]    maddr,
	output bus_pkg::word_t       mwdata,
	input  logic                 mgnt,
	input  bus_pkg::word_t       sram_rdata
);
	import bus_pkg::*;
	import mem_pkg::*;

	// byte offset inside the word
	logic [1:0] offset;

	// load format held from grant to data cycle
	access_t    ld_sel;
	logic [1:0] ld_off;

	// lanes picked out of the returned word
	logic [BYTE_W-1:0]   lane_byte;
	logic [2*BYTE_W-1:0] lane_half;
	logic                fill_bit;

	assign offset = addr[1:0];

	// request goes straight through to the arbiter
	assign mreq = req;

	// word address, low bits only steer lanes
	assign maddr = addr[ADDR_W-1:2];

	// store data lane replication
	always_comb begin
		case (sel)
			ACC_BYTE: begin
				mwdata = {STRB_W{wdata[BYTE_W-1:0]}};
			end
			ACC_HALF: begin
				mwdata = {2{wdata[2*BYTE_W-1:0]}};
			end
			default: begin
				mwdata = wdata;
			end
		endcase
	end

	// write strobes
	// loads never write
	always_comb begin
		if (!we) begin
			mwen = '0;
		end else begin
			case (sel)
				ACC_BYTE: begin
					// one lane, picked by both offset bits
					mwen = strb_t'(1) << offset;
				end
				ACC_HALF: begin
					// upper or lower pair by bit 1
					mwen = offset[1] ? 4'b1100 : 4'b0011;
				end
				default: begin
					mwen = '1;
				end
			endcase
		end
	end

	// capture load format on its grant cycle
	// sram data shows up one edge later
	always_ff @(posedge clk) begin
		if (mgnt && !we) begin
			ld_sel <= sel;
			ld_off <= offset;
		end
	end

	// read valid one cycle after a granted load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= mgnt && mreq && !we;
		end
	end

	// lane extraction from the sram word
	assign lane_byte = sram_rdata[{ld_off, 3'b000} +: BYTE_W];
	assign lane_half = ld_off[1] ? sram_rdata[WORD_W-1:2*BYTE_W]
		: sram_rdata[2*BYTE_W-1:0];

	// top bit to copy upward, zero for unsigned formats
	always_comb begin
		if (!is_signed_load(ld_sel)) begin
			fill_bit = 1'b0;
		end else if (is_byte_load(ld_sel)) begin
			fill_bit = lane_byte[BYTE_W-1];
		end else begin
			fill_bit = lane_half[2*BYTE_W-1];
		end
	end

	// load result formatting
	always_comb begin
		if (is_byte_load(ld_sel)) begin
			rdata = {{(WORD_W-BYTE_W){fill_bit}}, lane_byte};
		end else if (is_half_load(ld_sel)) begin
			rdata = {{(WORD_W-2*BYTE_W){fill_bit}}, lane_half};
		end else begin
			// byte, half, word and 111 read back whole
			rdata = sram_rdata;
		end
	end

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

	localparam int ACC_W = 3;

	// access code on each port's sel input
	// stores narrow only for byte and half
	// loads narrow only for the four extension formats
	// code 3'b111 is left unnamed and acts as a plain word
	typedef enum logic [ACC_W-1:0] {
		ACC_BYTE = 3'b000,
		ACC_HALF = 3'b001,
		ACC_WORD = 3'b010,
		ACC_LBU  = 3'b011,
		ACC_LB   = 3'b100,
		ACC_LHU  = 3'b101,
		ACC_LH   = 3'b110
	} access_t;

	// byte wide load formats
	function automatic logic is_byte_load(access_t sel);
		return (sel == ACC_LBU) || (sel == ACC_LB);
	endfunction

	// halfword wide load formats
	function automatic logic is_half_load(access_t sel);
		return (sel == ACC_LHU) || (sel == ACC_LH);
	endfunction

	// formats that copy the lane msb upward
	function automatic logic is_signed_load(access_t sel);
		return (sel == ACC_LB) || (sel == ACC_LH);
	endfunction

endpackage

/* verilog/sram_arbiter.sv */
`timescale 1ns/100ps

module sram_arbiter #(
	parameter int ADDR_W = 12
) (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic [bus_pkg::NUM_PORTS-1:0]                req,
	input  bus_pkg::strb_t [bus_pkg::NUM_PORTS-1:0]      wen,
	input  logic [bus_pkg::NUM_PORTS-1:0][ADDR_W-3:0]    addr,
	input  bus_pkg::word_t [bus_pkg::NUM_PORTS-1:0]      wdata,
	output logic [bus_pkg::NUM_PORTS-1:0]                gnt,
	output logic                                         sram_en,
	output bus_pkg::strb_t                               sram_wen,
	output logic [ADDR_W-3:0]                            sram_addr,
	output bus_pkg::word_t                               sram_wdata
);
	import bus_pkg::*;

	// port granted most recently
	port_id_t last;
	// port that has priority this cycle
	port_id_t pri;
	// port that wins this cycle
	port_id_t win;
	logic     any_req;

	assign any_req = |req;

	// round robin, the port after the last winner goes first
	assign pri = port_id_t'(last + 1'b1);

	// fall back to the other port if the favoured one is idle
	assign win = req[pri] ? pri : port_id_t'(~pri);

	// single grant, combinational in the request cycle
	always_comb begin
		gnt = '0;
		if (any_req) begin
			gnt[win] = 1'b1;
		end
	end

	// pointer moves on the grant edge only
	// reset points at b so a goes first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last <= port_id_t'(NUM_PORTS - 1);
		end else if (any_req) begin
			last <= win;
		end
	end

	// winner's fields onto the sram
	assign sram_en    = any_req;
	assign sram_wen   = any_req ? wen[win] : '0;
	assign sram_addr  = addr[win];
	assign sram_wdata = wdata[win];

endmodule
